// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // opcode encoding shared by both lanes and the testbench
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_mul  = 5'd3,
        op_div  = 5'd4,
        op_shr  = 5'd5,
        op_shl  = 5'd6,
        op_shra = 5'd7,
        op_ror  = 5'd8,
        op_rol  = 5'd9,
        op_and  = 5'd10,
        op_or   = 5'd11,
        op_neg  = 5'd12,
        op_xor  = 5'd13,
        op_nor  = 5'd14,
        op_not  = 5'd15
    } alu_op_e;

    // request as seen by both lanes
    typedef struct packed {
        logic    valid;
        alu_op_e op;
    } alu_req_t;

    // true for ops owned by the arithmetic lane
    function automatic logic op_is_arith(alu_op_e op);
        logic is_arith;
        is_arith = (op == op_add) || (op == op_sub) ||
                   (op == op_mul) || (op == op_div);
        return is_arith;
    endfunction

endpackage

`default_nettype wire

// ==== alu_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_divider #(
    parameter int word_size = 32
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 start,
    input  wire logic [word_size-1:0] dividend,
    input  wire logic [word_size-1:0] divisor,
    output logic      [word_size-1:0] quotient,
    output logic      [word_size-1:0] remainder,
    output logic                      done
);

    localparam int cnt_w = $clog2(word_size);
    localparam logic [cnt_w-1:0] last_count = cnt_w'(word_size - 1);

    typedef enum logic {
        st_idle,
        st_run
    } div_state_e;

    div_state_e           state;
    logic [cnt_w-1:0]     count;
    logic [word_size-1:0] rem_q;
    logic [word_size-1:0] quo_q;
    logic [word_size-1:0] dvs_q;
    logic [word_size:0]   partial;
    logic [word_size:0]   diff;
    logic                 fits;

    // shift in the next dividend bit and try the subtract
    assign partial = {rem_q, quo_q[word_size-1]};
    assign diff    = partial - {1'b0, dvs_q};
    // no borrow means the divisor fits; a zero divisor always fits
    assign fits    = ~diff[word_size];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    count <= count + 1'b1;
                    if (count == last_count) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // datapath, one quotient bit per run cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            rem_q <= '0;
            quo_q <= dividend;
            dvs_q <= divisor;
        end else if (state == st_run) begin
            rem_q <= fits ? diff[word_size-1:0] : partial[word_size-1:0];
            quo_q <= {quo_q[word_size-2:0], fits};
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

// ==== alu_arith.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_arith
    import alu_pkg::*;
#(
    parameter int word_size = 32
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire alu_req_t               req,
    input  wire logic [word_size-1:0]   a,
    input  wire logic [word_size-1:0]   b,
    input  wire logic [word_size-1:0]   y,
    output logic                        arith_valid,
    output logic [2*word_size-1:0]      arith_data,
    output logic                        busy
);

    logic                   claim;
    logic                   div_start;
    logic                   div_done;
    logic [word_size-1:0]   quotient;
    logic [word_size-1:0]   remainder;
    logic [word_size:0]     sum;
    logic [2*word_size-1:0] product;
    logic [2*word_size-1:0] comb_data;

    // requests during a divide are dropped
    assign claim     = req.valid && op_is_arith(req.op) && !busy;
    assign div_start = claim && (req.op == op_div);

    assign sum     = {1'b0, y} + {1'b0, b};
    assign product = {{word_size{1'b0}}, a} * {{word_size{1'b0}}, b};

    always_comb begin
        case (req.op)
            // carry-out lands in bit word_size of c
            op_add:  comb_data = {{(word_size-1){1'b0}}, sum};
            op_sub:  comb_data = {{word_size{1'b0}}, y - b};
            op_mul:  comb_data = product;
            default: comb_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (div_start) begin
            busy <= 1'b1;
        end else if (div_done) begin
            busy <= 1'b0;
        end
    end

    alu_divider #(
        .word_size (word_size)
    ) u_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .dividend  (a),
        .divisor   (b),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    // single-cycle ops answer at once, divide answers on done
    assign arith_valid = (claim && (req.op != op_div)) || div_done;
    assign arith_data  = div_done ? {remainder, quotient} : comb_data;

    // issuer must wait for the divide to finish
    assert property (@(posedge clk) disable iff (!arst_n) busy |-> !req.valid)
        else $error("request issued while a divide is in flight");

    // divider can only finish a divide this lane started
    assert property (@(posedge clk) disable iff (!arst_n) div_done |-> busy)
        else $error("divider done without a running divide");

endmodule

`default_nettype wire

// ==== alu_bitops.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_bitops
    import alu_pkg::*;
#(
    parameter int word_size = 32
) (
    input  wire alu_req_t             req,
    input  wire logic [word_size-1:0] b,
    input  wire logic [word_size-1:0] y,
    output logic                      bit_valid,
    output logic [2*word_size-1:0]    bit_data
);

    localparam int sh_w = $clog2(word_size);

    logic [sh_w-1:0]        s;
    logic [2*word_size-1:0] ror_wide;
    logic [2*word_size-1:0] rol_wide;
    logic [word_size-1:0]   result;

    // shift amount is the low bits of b only
    assign s = b[sh_w-1:0];

    // rotates via a doubled copy of y
    assign ror_wide = {y, y} >> s;
    assign rol_wide = {y, y} << s;

    always_comb begin
        case (req.op)
            op_shr:  result = y >> s;
            op_shl:  result = y << s;
            op_shra: result = $unsigned($signed(y) >>> s);
            op_ror:  result = ror_wide[word_size-1:0];
            op_rol:  result = rol_wide[2*word_size-1:word_size];
            op_and:  result = y & b;
            op_or:   result = y | b;
            op_xor:  result = y ^ b;
            op_nor:  result = ~(y | b);
            op_neg:  result = -y;
            op_not:  result = ~y;
            // nop and undefined opcodes
            default: result = '0;
        endcase
    end

    // everything the arithmetic lane does not claim ends up here
    assign bit_valid = req.valid && !op_is_arith(req.op);
    assign bit_data  = {{word_size{1'b0}}, result};

endmodule

`default_nettype wire

// ==== alu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_result #(
    parameter int word_size = 32
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   arith_valid,
    input  wire logic [2*word_size-1:0] arith_data,
    input  wire logic                   bit_valid,
    input  wire logic [2*word_size-1:0] bit_data,
    output logic      [2*word_size-1:0] c,
    output logic                        result_valid
);

    logic                   lane_valid;
    logic [2*word_size-1:0] lane_data;

    // lanes are one-hot, so a plain select is enough
    assign lane_valid = arith_valid || bit_valid;
    assign lane_data  = arith_valid ? arith_data : bit_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            c            <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= lane_valid;
            // c holds between results
            if (lane_valid) begin
                c <= lane_data;
            end
        end
    end

    // a divide finishing while the bit lane answers would lose a result
    assert property (@(posedge clk) disable iff (!arst_n) !(arith_valid && bit_valid))
        else $error("both lanes delivered in the same cycle");

endmodule

`default_nettype wire

// ==== alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core
    import alu_pkg::*;
#(
    parameter int word_size = 32
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   op_valid,
    input  wire logic [4:0]             opcode,
    input  wire logic [word_size-1:0]   a,
    input  wire logic [word_size-1:0]   b,
    input  wire logic [word_size-1:0]   y,
    output logic      [2*word_size-1:0] c,
    output logic                        result_valid,
    output logic                        busy
);

    alu_req_t               req;
    logic                   arith_valid;
    logic [2*word_size-1:0] arith_data;
    logic                   bit_valid;
    logic [2*word_size-1:0] bit_data;

    // undefined opcodes pass through and fall to the bit lane default
    assign req = '{valid: op_valid, op: alu_op_e'(opcode)};

    alu_arith #(
        .word_size   (word_size)
    ) u_arith (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .a           (a),
        .b           (b),
        .y           (y),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .busy        (busy)
    );

    alu_bitops #(
        .word_size (word_size)
    ) u_bitops (
        .req       (req),
        .b         (b),
        .y         (y),
        .bit_valid (bit_valid),
        .bit_data  (bit_data)
    );

    alu_result #(
        .word_size    (word_size)
    ) u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .arith_valid  (arith_valid),
        .arith_data   (arith_data),
        .bit_valid    (bit_valid),
        .bit_data     (bit_data),
        .c            (c),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== alu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_checker
    import alu_pkg::*;
#(
    parameter int word_size = 32
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   op_valid,
    input  wire logic [4:0]             opcode,
    input  wire logic [2*word_size-1:0] c,
    input  wire logic                   result_valid,
    input  wire logic                   busy,
    input  wire logic [2*word_size-1:0] exp_c,
    input  wire logic [31:0]            test_id,
    output int                          pass_count,
    output int                          fail_count,
    output int                          error_count
);

    int                     cycle = 0;
    int                     issue_cycle = 0;
    logic                   pending = 1'b0;
    logic                   is_div = 1'b0;
    logic                   cur_bad = 1'b0;
    logic [4:0]             cur_op = '0;
    logic [31:0]            cur_id = '0;
    logic [2*word_size-1:0] cur_exp = '0;
    logic [2*word_size-1:0] last_c = '0;

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
    end

    // between results c must hold and busy only runs for a divide
    task automatic check_idle();
        if (c !== last_c) begin
            $display("error at %0t ns: c changed to %h without result_valid, held %h",
                     $time, c, last_c);
            error_count = error_count + 1;
            cur_bad = pending;
            last_c = c;
        end
        if (busy !== (pending && is_div)) begin
            $display("error at %0t ns: busy is %b, expected %b", $time, busy,
                     pending && is_div);
            error_count = error_count + 1;
            cur_bad = pending;
        end
    endtask

    task automatic finish_test();
        int latency;
        int exp_latency;
        latency = cycle - issue_cycle;
        exp_latency = is_div ? word_size + 2 : 1;
        if (!pending) begin
            $display("result_valid pulsed at %0t ns with no request outstanding", $time);
            error_count = error_count + 1;
        end else if (c !== cur_exp) begin
            $display("error at %0t ns: test %0d opcode %0d gave c = %h, expected %h",
                     $time, cur_id, cur_op, c, cur_exp);
            fail_count = fail_count + 1;
        end else if (latency != exp_latency) begin
            $display("test %0d opcode %0d took %0d cycles instead of %0d",
                     cur_id, cur_op, latency, exp_latency);
            fail_count = fail_count + 1;
        end else if (busy !== 1'b0 || cur_bad) begin
            $display("test %0d opcode %0d had busy wrong while it ran", cur_id, cur_op);
            fail_count = fail_count + 1;
        end else begin
            $display("test %0d opcode %0d ok, c = %h", cur_id, cur_op, c);
            pass_count = pass_count + 1;
        end
        last_c = c;
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            pending = 1'b0;
            last_c = '0;
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (result_valid) begin
                finish_test();
            end else begin
                check_idle();
            end
            // request seen at this edge
            if (op_valid) begin
                pending = 1'b1;
                cur_bad = 1'b0;
                is_div = (opcode == op_div);
                issue_cycle = cycle;
                cur_op = opcode;
                cur_id = test_id;
                cur_exp = exp_c;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alu_core
    import alu_pkg::*;
();

    localparam int word_size    = 32;
    localparam int reset_cycles = 5;

    typedef struct packed {
        logic [4:0]             op;
        logic [word_size-1:0]   a;
        logic [word_size-1:0]   b;
        logic [word_size-1:0]   y;
        logic [2*word_size-1:0] exp_c;
    } stim_row_t;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   op_valid;
    logic [4:0]             opcode;
    logic [word_size-1:0]   a;
    logic [word_size-1:0]   b;
    logic [word_size-1:0]   y;
    logic [2*word_size-1:0] c;
    logic                   result_valid;
    logic                   busy;
    logic [2*word_size-1:0] exp_c;
    logic [31:0]            test_id;
    int                     pass_count;
    int                     fail_count;
    int                     error_count;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;
    int                     seed = 32'h3822;
    stim_row_t              stim_q[$];

    always #2 clk = ~clk;

    alu_core #(.word_size(word_size)) DUT (
        .clk(clk), .arst_n(arst_n), .op_valid(op_valid), .opcode(opcode),
        .a(a), .b(b), .y(y), .c(c), .result_valid(result_valid), .busy(busy)
    );

    alu_checker #(.word_size(word_size)) u_checker (
        .clk(clk), .arst_n(arst_n), .op_valid(op_valid), .opcode(opcode),
        .c(c), .result_valid(result_valid), .busy(busy), .exp_c(exp_c),
        .test_id(test_id), .pass_count(pass_count), .fail_count(fail_count),
        .error_count(error_count)
    );

    // expected c straight from the result rules
    function automatic logic [2*word_size-1:0] model_c(logic [4:0] op,
            logic [word_size-1:0] a_in, logic [word_size-1:0] b_in,
            logic [word_size-1:0] y_in);
        int s;
        logic [word_size-1:0] lo;
        logic [word_size-1:0] hi;
        logic [word_size-1:0] ones;
        s = b_in % word_size;
        lo = '0;
        hi = '0;
        ones = '1;
        case (op)
            op_add:  {hi[0], lo} = y_in + b_in;
            op_sub:  lo = y_in - b_in;
            op_mul:  {hi, lo} = a_in * b_in;
            op_div:  begin
                lo = (b_in == 0) ? ones : a_in / b_in;
                hi = (b_in == 0) ? a_in : a_in % b_in;
            end
            op_shr:  lo = y_in >> s;
            op_shl:  lo = y_in << s;
            op_shra: lo = (y_in >> s) | (y_in[word_size-1] ? ~(ones >> s) : '0);
            op_ror:  lo = (s == 0) ? y_in : (y_in >> s) | (y_in << (word_size - s));
            op_rol:  lo = (s == 0) ? y_in : (y_in << s) | (y_in >> (word_size - s));
            op_and:  lo = y_in & b_in;
            op_or:   lo = y_in | b_in;
            op_xor:  lo = y_in ^ b_in;
            op_nor:  lo = ~(y_in | b_in);
            op_neg:  lo = ~y_in + 1'b1;
            op_not:  lo = ~y_in;
            default: lo = '0;
        endcase
        return {hi, lo};
    endfunction

    task automatic add_row(logic [4:0] op, logic [31:0] a_in, logic [31:0] b_in,
                           logic [31:0] y_in, logic [63:0] exp_in);
        stim_q.push_back('{op: op, a: a_in, b: b_in, y: y_in, exp_c: exp_in});
    endtask

    task automatic build_table();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] ry;
        add_row(op_add, 32'h1111_1111, 32'h0000_0007, 32'h0000_0005, 64'h0000_0000_0000_000c);
        add_row(op_add, 32'h0, 32'h0000_0001, 32'hffff_ffff, 64'h0000_0001_0000_0000);
        add_row(op_add, 32'h0, 32'h8000_0001, 32'h8000_0000, 64'h0000_0001_0000_0001);
        add_row(op_sub, 32'h0, 32'h0000_0003, 32'h0000_000a, 64'h0000_0000_0000_0007);
        add_row(op_sub, 32'h0, 32'h0000_000a, 32'h0000_0003, 64'h0000_0000_ffff_fff9);
        add_row(op_mul, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 64'hffff_fffe_0000_0001);
        add_row(op_mul, 32'h0001_0000, 32'h0001_0000, 32'h0, 64'h0000_0001_0000_0000);
        add_row(op_mul, 32'h1234_5678, 32'h0000_0010, 32'h0, 64'h0000_0001_2345_6780);
        add_row(op_div, 32'd100, 32'd7, 32'h0, 64'h0000_0002_0000_000e);
        add_row(op_div, 32'hdead_beef, 32'h0, 32'h0, 64'hdead_beef_ffff_ffff);
        add_row(op_div, 32'hffff_ffff, 32'h1, 32'h0, 64'h0000_0000_ffff_ffff);
        add_row(op_div, 32'd5, 32'd9, 32'h0, 64'h0000_0005_0000_0000);
        add_row(op_shr, 32'h0, 32'd0, 32'hf000_000f, 64'h0000_0000_f000_000f);
        add_row(op_shr, 32'h0, 32'd31, 32'h8000_0000, 64'h0000_0000_0000_0001);
        add_row(op_shr, 32'h0, 32'd33, 32'hf000_0000, 64'h0000_0000_7800_0000);
        add_row(op_shl, 32'h0, 32'd31, 32'h0000_0001, 64'h0000_0000_8000_0000);
        add_row(op_shl, 32'h0, 32'd33, 32'h0000_0003, 64'h0000_0000_0000_0006);
        add_row(op_shra, 32'h0, 32'd31, 32'h8000_0000, 64'h0000_0000_ffff_ffff);
        add_row(op_shra, 32'h0, 32'd0, 32'h8000_0000, 64'h0000_0000_8000_0000);
        add_row(op_shra, 32'h0, 32'd33, 32'h8000_0004, 64'h0000_0000_c000_0002);
        add_row(op_ror, 32'h0, 32'd0, 32'h1234_5678, 64'h0000_0000_1234_5678);
        add_row(op_ror, 32'h0, 32'd33, 32'h8765_4321, 64'h0000_0000_c3b2_a190);
        add_row(op_rol, 32'h0, 32'd31, 32'h1234_5678, 64'h0000_0000_091a_2b3c);
        add_row(op_rol, 32'h0, 32'd36, 32'habcd_ef01, 64'h0000_0000_bcde_f01a);
        add_row(op_and, 32'h0, 32'hff00_ff00, 32'hf0f0_f0f0, 64'h0000_0000_f000_f000);
        add_row(op_or, 32'h0, 32'hff00_ff00, 32'hf0f0_f0f0, 64'h0000_0000_fff0_fff0);
        add_row(op_xor, 32'h0, 32'hff00_ff00, 32'hf0f0_f0f0, 64'h0000_0000_0ff0_0ff0);
        add_row(op_nor, 32'h0, 32'hff00_ff00, 32'hf0f0_f0f0, 64'h0000_0000_000f_000f);
        add_row(op_neg, 32'h0, 32'h0, 32'h0000_0000, 64'h0000_0000_0000_0000);
        add_row(op_neg, 32'h0, 32'h0, 32'h8000_0000, 64'h0000_0000_8000_0000);
        add_row(op_neg, 32'h0, 32'h0, 32'h0000_0001, 64'h0000_0000_ffff_ffff);
        add_row(op_not, 32'h0, 32'h0, 32'h0f0f_0000, 64'h0000_0000_f0f0_ffff);
        add_row(op_nop, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 64'h0);
        add_row(5'd31, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 64'h0);
        // one random row per defined opcode
        for (int i = 0; i < 16; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            ry = $random(seed);
            add_row(5'(i), ra, rb, ry, model_c(5'(i), ra, rb, ry));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: test %0d got no result, run stopped after %0d cycles",
                     test_id, cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        arst_n = 1'b0;
        op_valid = 1'b0;
        opcode = '0;
        a = '0;
        b = '0;
        y = '0;
        exp_c = '0;
        test_id = '0;
        build_table();
        cycle_limit = stim_q.size() * (word_size + 4) + reset_cycles;
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        // idle cycles so the checker sees the reset values
        repeat (3) @(negedge clk);
        foreach (stim_q[i]) begin
            test_id = i;
            opcode = stim_q[i].op;
            a = stim_q[i].a;
            b = stim_q[i].b;
            y = stim_q[i].y;
            exp_c = stim_q[i].exp_c;
            op_valid = 1'b1;
            @(negedge clk);
            op_valid = 1'b0;
            while (!result_valid) @(negedge clk);
            // uneven gaps so c has to hold
            repeat (1 + i % 3) @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 stim_q.size(), pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0 && pass_count == stim_q.size()) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_core.f ====
alu_pkg.sv
alu_divider.sv
alu_arith.sv
alu_bitops.sv
alu_result.sv
alu_core.sv
alu_checker.sv
tb_alu_core.sv

// ==== Makefile ====
# Verilator build and run for the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_core
RTL_TOP   ?= alu_core
FILELIST  ?= alu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
